/* mmr.sv */
`timescale 1ns/1ps
`default_nettype none

module mmr
    import tenyr_pkg::*;
#(
    parameter reg_val_t DEFAULT = '0
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           wr_strobe,
    input  wire reg_val_t wr_val,
    input  wire           hw_we,
    input  wire reg_val_t hw_val,
    output reg_val_t      val
);

    always_ff @(posedge clk) begin
        if (reset) begin
            val <= DEFAULT;
        end else if (wr_strobe) begin
            val <= wr_val; // the bus wins when both land in one cycle.
        end else if (hw_we) begin
            val <= hw_val;
        end
    end

endmodule

`default_nettype wire

/* mmr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mmr_decoder
    import tenyr_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              cyc,
    input  wire              stb,
    input  wire              we,
    input  wire bus_addr_t   adr,
    input  wire bus_data_t   dat_w,
    output logic [NUM_REGS-1:0] wr_strobe,
    output reg_val_t         wr_val,
    output logic             rd_req,
    output reg_idx_t         rd_idx,
    output logic             rd_hit
);

    dec_state_t state;
    bus_addr_t  offset;
    logic       accept;

    // an address below the base wraps to a large offset and misses.
    assign offset = adr - MMR_BASE;
    assign rd_hit = offset < bus_addr_t'(NUM_REGS);
    assign rd_idx = offset[$bits(reg_idx_t)-1:0];

    // a request is taken only once, while the FSM waits in idle.
    assign accept = cyc && stb && (state == DEC_IDLE);
    assign rd_req = accept; // writes are acknowledged through the read path too.
    assign wr_val = dat_w[$bits(reg_val_t)-1:0];

    always_comb begin
        wr_strobe = '0;
        if (accept && we && rd_hit) begin
            wr_strobe[rd_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DEC_IDLE;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        state <= DEC_ACK;
                    end
                end
                DEC_ACK: state <= DEC_IDLE; // the ack cycle blocks a second accept.
                default: state <= DEC_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* mmr_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module mmr_read_mux
    import tenyr_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           rd_req,
    input  wire reg_idx_t rd_idx,
    input  wire           rd_hit,
    input  wire reg_val_t reg_vals [NUM_REGS],
    output bus_data_t     dat_r,
    output logic          ack
);

    bus_data_t rd_data;

    // unmapped addresses read back as zero.
    always_comb begin
        rd_data = '0;
        if (rd_hit) begin
            rd_data = bus_data_t'(reg_vals[rd_idx]);
        end
    end

    // data and ack leave together, one clock after the request.
    always_ff @(posedge clk) begin
        if (reset) begin
            ack   <= 1'b0;
            dat_r <= '0;
        end else begin
            ack <= rd_req;
            if (rd_req) begin
                dat_r <= rd_data; // a write returns the value it replaced.
            end
        end
    end

endmodule

`default_nettype wire

/* seg7_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_scan
    import tenyr_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire [15:0] value,
    output seg_t       seg,
    output an_t        an
);

    logic [SCAN_BITS-1:0] prescale;
    logic [1:0]           digit;
    nibble_t              nib;
    seg_t                 pattern;

    // the digit steps once every time the prescaler wraps.
    always_ff @(posedge clk) begin
        if (reset) begin
            prescale <= '0;
            digit    <= '0;
        end else begin
            prescale <= prescale + 1'b1;
            if (&prescale) begin
                digit <= digit + 1'b1;
            end
        end
    end

    assign nib = value[{digit, 2'b00} +: 4];

    // Segment a is bit 0 and g is bit 6.
    always_comb begin
        case (nib)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83;
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1;
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;
        endcase
    end

    // seg and an come from the same digit count, so they never disagree.
    always_ff @(posedge clk) begin
        if (reset) begin
            seg <= '1;      // blank until the first scan.
            an  <= 4'b1110;
        end else begin
            seg <= pattern;
            an  <= ~(an_t'(1) << digit);
        end
    end

endmodule

`default_nettype wire

/* tenyr_mmio_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyr_mmio_sva
    import tenyr_pkg::*;
(
    input wire                clk,
    input wire                reset,
    input wire                cyc,
    input wire                stb,
    input wire                we,
    input wire                ack,
    input wire [NUM_REGS-1:0] wr_strobe,
    input wire an_t           an
);

    // ack is a single-cycle pulse.
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack stayed high for two cycles");

    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        ack |-> $past(cyc && stb))
        else $error("ack without a bus request in the previous cycle");

    // a strobe belongs to an accepted write and never to the ack cycle.
    strobe_one_hot: assert property (@(posedge clk) disable iff (reset)
        (wr_strobe != '0) |-> ($onehot(wr_strobe) && cyc && stb && we && !ack))
        else $error("write strobe not one-hot or outside an accepted write");

    // the low anode bit steps from digit 0 up to digit 3 and wraps.
    anode_one_low: assert property (@(posedge clk) disable iff (reset)
        $onehot(~an) && (an == $past(an) || an == $past({an[2:0], an[3]})))
        else $error("anode select is not one low bit stepping to the next digit");

endmodule

bind tenyr_mmio_top tenyr_mmio_sva sva0 (
    .clk       (clk),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .ack       (ack),
    .wr_strobe (wr_strobe),
    .an        (an)
);

`default_nettype wire

/* tenyr_mmio_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyr_mmio_tb
    import tenyr_pkg::*;
;

    localparam int CLK_PERIOD  = 40;
    localparam int TABLE_MAX   = 64;
    localparam int SCAN_CYCLES = 10 << SCAN_BITS;
    localparam int unsigned SEED = 32'h1eb8_2f86;

    typedef enum {OP_READ, OP_WRITE, OP_HW, OP_BOTH} op_t;

    logic                clk;
    logic                reset;
    logic                cyc;
    logic                stb;
    logic                we;
    bus_addr_t           adr;
    bus_data_t           dat_w;
    logic [NUM_REGS-1:0] hw_we;
    reg_val_t            hw_val;
    bus_data_t           dat_r;
    logic                ack;
    seg_t                seg;
    an_t                 an;

    string     tbl_name [TABLE_MAX];
    op_t       tbl_op   [TABLE_MAX];
    bus_addr_t tbl_addr [TABLE_MAX];
    bus_data_t tbl_data [TABLE_MAX];
    bus_data_t tbl_exp  [TABLE_MAX];
    int        num_entries = 0;
    int        pass_count = 0;
    int        fail_count = 0;

    // reset values of video control, cursor x, cursor y and the display bytes.
    reg_val_t  shadow [NUM_REGS] = '{8'hF7, 8'd40, 8'd20, 8'h00, 8'h00};
    reg_val_t  disp_lo = 8'h7E;
    reg_val_t  disp_hi = 8'hD2;

    tenyr_mmio_top dut0 (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .hw_we(hw_we), .hw_val(hw_val), .dat_r(dat_r), .ack(ack),
        .seg(seg), .an(an)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // standard segment sets with a in bit 0, inverted for the active-low pins.
    function automatic seg_t hex_seg(input nibble_t n);
        logic [6:0] lit [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return {1'b1, ~lit[n]};
    endfunction

    task automatic add_entry(input string name, input op_t op, input bus_addr_t a,
                             input bus_data_t d, input bus_data_t exp);
        tbl_name[num_entries] = name;
        tbl_op[num_entries]   = op;
        tbl_addr[num_entries] = a;
        tbl_data[num_entries] = d;
        tbl_exp[num_entries]  = exp;
        num_entries++;
    endtask

    task automatic add_read_all(input string tag);
        for (int j = 0; j < NUM_REGS; j++) begin
            add_entry($sformatf("%s_rd%0d", tag, j), OP_READ, MMR_BASE + j, '0, shadow[j]);
        end
    endtask

    task automatic build_table();
        bus_data_t d;
        add_read_all("default");
        for (int i = 0; i < NUM_REGS; i++) begin
            d = $urandom;
            add_entry($sformatf("write_%0d", i), OP_WRITE, MMR_BASE + i, d, '0);
            shadow[i] = d[7:0];
            add_read_all($sformatf("after_wr%0d", i));
        end
        add_entry("unmapped_rd_base5", OP_READ, MMR_BASE + NUM_REGS, '0, '0);
        add_entry("unmapped_rd_000", OP_READ, 12'h000, '0, '0);
        add_entry("unmapped_wr", OP_WRITE, MMR_BASE + NUM_REGS, $urandom, '0);
        add_read_all("after_unmapped");
        d = $urandom;
        add_entry("hw_update_crx", OP_HW, MMR_BASE + IDX_CRX, d, '0);
        shadow[IDX_CRX] = d[7:0];
        add_entry("hw_update_crx_rd", OP_READ, MMR_BASE + IDX_CRX, '0, shadow[IDX_CRX]);
        d = $urandom;
        add_entry("bus_beats_hw_cry", OP_BOTH, MMR_BASE + IDX_CRY, d, '0);
        shadow[IDX_CRY] = d[7:0];
        add_entry("bus_beats_hw_cry_rd", OP_READ, MMR_BASE + IDX_CRY, '0, shadow[IDX_CRY]);
        add_entry("write_disp_lo", OP_WRITE, MMR_BASE + IDX_DISP_LO, disp_lo, '0);
        add_entry("write_disp_hi", OP_WRITE, MMR_BASE + IDX_DISP_HI, disp_hi, '0);
    endtask

    // one classic cycle; hw_we rides along for the request cycle only.
    task automatic bus_cycle(input logic wr, input bus_addr_t a, input bus_data_t d,
                             input logic [NUM_REGS-1:0] hw_mask, input reg_val_t hv,
                             output bus_data_t rdata);
        @(posedge clk);
        cyc    <= 1'b1;
        stb    <= 1'b1;
        we     <= wr;
        adr    <= a;
        dat_w  <= d;
        hw_we  <= hw_mask;
        hw_val <= hv;
        @(posedge clk);
        hw_we <= '0;
        @(negedge clk);
        while (ack !== 1'b1) @(negedge clk);
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_write(input bus_addr_t a, input bus_data_t d);
        bus_data_t unused;
        bus_cycle(1'b1, a, d, '0, '0, unused);
    endtask

    task automatic bus_read(input bus_addr_t a, output bus_data_t rdata);
        bus_cycle(1'b0, a, '0, '0, '0, rdata);
    endtask

    task automatic hw_update(input logic [NUM_REGS-1:0] mask, input reg_val_t v);
        @(posedge clk);
        hw_we  <= mask;
        hw_val <= v;
        @(posedge clk);
        hw_we  <= '0;
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act === exp) begin
            $display("ok       %s: 0x%08h", name, act);
            pass_count++;
        end else begin
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            fail_count++;
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (act === exp) begin
            $display("ok       %s: 0x%02h", name, act);
            pass_count++;
        end else begin
            $display("** Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            fail_count++;
        end
    endtask

    task automatic check_an(input string name, input an_t exp, input an_t act);
        if (act === exp) begin
            $display("ok       %s: %04b", name, act);
            pass_count++;
        end else begin
            $display("** Error %s: expected %04b, actual %04b", name, exp, act);
            fail_count++;
        end
    endtask

    initial begin
        wait (num_entries > 0);
        #((num_entries * 40 + SCAN_CYCLES + 10) * CLK_PERIOD);
        $display("timeout: the bus or the display scan stopped responding in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        bus_data_t              rdata;
        logic [NUM_REGS-1:0]    mask;
        an_t                    want_an;
        logic [15:0]            disp;
        void'($urandom(SEED));
        clk = 1'b0;
        reset = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        hw_we = '0;
        hw_val = '0;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_data("reset_dat_r", '0, dat_r);
        check_data("reset_ack", '0, bus_data_t'(ack));
        check_an("reset_an", 4'b1110, an);

        for (int e = 0; e < num_entries; e++) begin
            repeat ($urandom % 4) @(posedge clk);
            mask = '0;
            mask[tbl_addr[e] - MMR_BASE] = 1'b1;
            case (tbl_op[e])
                OP_READ: begin
                    bus_read(tbl_addr[e], rdata);
                    check_data(tbl_name[e], tbl_exp[e], rdata);
                end
                OP_WRITE: bus_write(tbl_addr[e], tbl_data[e]);
                OP_HW:    hw_update(mask, tbl_data[e][7:0]);
                default:  bus_cycle(1'b1, tbl_addr[e], tbl_data[e], mask,
                                    ~tbl_data[e][7:0], rdata);
            endcase
        end

        // start on the first clock of digit 0, so each later digit is one scan period on.
        disp = {disp_hi, disp_lo};
        @(negedge clk);
        while (an !== 4'b0111) @(negedge clk);
        while (an === 4'b0111) @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            want_an = '1;
            want_an[k] = 1'b0;
            check_an($sformatf("scan_an_%0d", k), want_an, an);
            check_seg($sformatf("scan_seg_%0d", k), hex_seg(disp[4*k +: 4]), seg);
            repeat (1 << SCAN_BITS) @(negedge clk);
        end

        $display("%0d checks, %0d passed, %0d failed", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tenyr_mmio_top.f */
tenyr_pkg.sv
mmr_decoder.sv
mmr.sv
mmr_read_mux.sv
seg7_scan.sv
tenyr_mmio_top.sv
tenyr_mmio_sva.sv
tenyr_mmio_tb.sv

/* tenyr_mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyr_mmio_top
    import tenyr_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire                cyc,
    input  wire                stb,
    input  wire                we,
    input  wire bus_addr_t     adr,
    input  wire bus_data_t     dat_w,
    input  wire [NUM_REGS-1:0] hw_we,
    input  wire reg_val_t      hw_val,
    output bus_data_t          dat_r,
    output logic               ack,
    output seg_t               seg,
    output an_t                an
);

    logic [NUM_REGS-1:0] wr_strobe;
    reg_val_t            wr_val;
    logic                rd_req;
    reg_idx_t            rd_idx;
    logic                rd_hit;
    reg_val_t            reg_vals [NUM_REGS];

    mmr_decoder decoder (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .wr_strobe (wr_strobe),
        .wr_val    (wr_val),
        .rd_req    (rd_req),
        .rd_idx    (rd_idx),
        .rd_hit    (rd_hit)
    );

    // video control, cursor x and y, then the two display bytes.
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_regs
        mmr #(.DEFAULT(REG_DEFAULTS[i])) regs (
            .clk       (clk),
            .reset     (reset),
            .wr_strobe (wr_strobe[i]),
            .wr_val    (wr_val),
            .hw_we     (hw_we[i]),
            .hw_val    (hw_val),
            .val       (reg_vals[i])
        );
    end

    mmr_read_mux read_mux (
        .clk      (clk),
        .reset    (reset),
        .rd_req   (rd_req),
        .rd_idx   (rd_idx),
        .rd_hit   (rd_hit),
        .reg_vals (reg_vals),
        .dat_r    (dat_r),
        .ack      (ack)
    );

    seg7_scan scan (
        .clk   (clk),
        .reset (reset),
        .value ({reg_vals[IDX_DISP_HI], reg_vals[IDX_DISP_LO]}),
        .seg   (seg),
        .an    (an)
    );

endmodule

`default_nettype wire

/* tenyr_pkg.sv */
`default_nettype none

package tenyr_pkg;

    typedef logic [11:0] bus_addr_t; // wishbone word address.
    typedef logic [31:0] bus_data_t;
    typedef logic [7:0]  reg_val_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  seg_t;      // active low, decimal point in bit 7.
    typedef logic [3:0]  an_t;       // active low digit select.

    localparam int NUM_REGS = 5;
    localparam bus_addr_t MMR_BASE = 12'h100;

    // the displayed digit moves on every 2**SCAN_BITS clocks.
    localparam int SCAN_BITS = 4;

    localparam reg_idx_t IDX_VIDEO_CTL = 3'd0;
    localparam reg_idx_t IDX_CRX       = 3'd1;
    localparam reg_idx_t IDX_CRY       = 3'd2;
    localparam reg_idx_t IDX_DISP_LO   = 3'd3;
    localparam reg_idx_t IDX_DISP_HI   = 3'd4;

    // cursor x and y start near the middle of an 80x40 text screen.
    localparam reg_val_t REG_DEFAULTS [NUM_REGS] = '{
        IDX_VIDEO_CTL: 8'hF7,
        IDX_CRX:       8'd40,
        IDX_CRY:       8'd20,
        IDX_DISP_LO:   8'h00,
        IDX_DISP_HI:   8'h00
    };

    typedef enum logic {
        DEC_IDLE,
        DEC_ACK
    } dec_state_t;

endpackage

`default_nettype wire
